/* verilog/soc_cfg.svh */
// Data bus fabric configuration: address decode bits, RAM depth and register offsets.
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Target decode bits, applied in priority order RAM, timer, PWM.
`define SOC_RAM_SEL_BIT 30
`define SOC_TMR_SEL_BIT 28
`define SOC_PWM_SEL_BIT 29

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SOC_RAM_WORDS     256     // Word index comes from address bits 9..2.
`define SOC_OFS_BITS      4       // Register offset field width.

`define SOC_TMR_COUNT_OFS 4'h0    // Read only.
`define SOC_TMR_CMP_OFS   4'h4
`define SOC_PWM_PER0_OFS  4'h0
`define SOC_PWM_DUTY0_OFS 4'h4
`define SOC_PWM_PER1_OFS  4'h8
`define SOC_PWM_DUTY1_OFS 4'hC

`endif

/* verilog/soc_pkg.sv */
// Data bus fabric package: bus word, address and mask types and the target select enum.
package soc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus payload types

    typedef logic [31:0] bus_word_t;    // Read and write data.
    typedef logic [31:0] bus_addr_t;    // Byte address.
    typedef logic [3:0]  bus_mask_t;    // Byte write enables, zero is a read.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Target of a request

    typedef enum logic [1:0] {
        TGT_RAM   = 2'd0,
        TGT_TIMER = 2'd1,
        TGT_PWM   = 2'd2,
        TGT_NONE  = 2'd3
    } target_e;

endpackage

/* verilog/bus_decoder.sv */
// Address decoder: turns the core address and select into one-hot target selects.
`timescale 1ns/1ns
`include "soc_cfg.svh"

module bus_decoder (
    input  logic              bus_sel_i,
    input  soc_pkg::bus_addr_t bus_addr_i,
    output logic              ram_sel_o,
    output logic              tmr_sel_o,
    output logic              pwm_sel_o,
    output soc_pkg::target_e  tgt_o
);

    soc_pkg::target_e tgt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prioritized decode, independent of select so the return path is
    // always defined.

    always_comb begin
        if (bus_addr_i[`SOC_RAM_SEL_BIT]) begin
            tgt = soc_pkg::TGT_RAM;
        end else if (bus_addr_i[`SOC_TMR_SEL_BIT]) begin
            tgt = soc_pkg::TGT_TIMER;
        end else if (bus_addr_i[`SOC_PWM_SEL_BIT]) begin
            tgt = soc_pkg::TGT_PWM;
        end else begin
            tgt = soc_pkg::TGT_NONE;                // Unmapped space.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Target selects

    assign ram_sel_o = bus_sel_i && (tgt == soc_pkg::TGT_RAM);
    assign tmr_sel_o = bus_sel_i && (tgt == soc_pkg::TGT_TIMER);
    assign pwm_sel_o = bus_sel_i && (tgt == soc_pkg::TGT_PWM);

    assign tgt_o = tgt;

endmodule

/* verilog/scratch_ram.sv */
// Scratch RAM: byte-masked word array with one wait state on every access.
`timescale 1ns/1ns
`include "soc_cfg.svh"

module scratch_ram (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               sel_i,
    input  soc_pkg::bus_addr_t addr_i,
    input  soc_pkg::bus_word_t wdata_i,
    input  soc_pkg::bus_mask_t mask_i,
    output soc_pkg::bus_word_t rdata_o,
    output logic               stall_o
);

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);
    localparam int BYTES = $bits(soc_pkg::bus_mask_t);

    soc_pkg::bus_word_t mem [`SOC_RAM_WORDS];
    soc_pkg::bus_word_t rdata_q;
    logic               wait_q;
    logic [IDX_W-1:0]   idx;

    assign idx = addr_i[IDX_W+1:2];                 // Word index.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Wait flag

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= 1'b0;
        end else if (sel_i) begin
            wait_q <= ~wait_q;                      // Set first cycle, clear on completion.
        end else begin
            wait_q <= 1'b0;
        end
    end

    assign stall_o = sel_i && !wait_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage

    always_ff @(posedge clk_i) begin
        if (sel_i && !wait_q) begin
            rdata_q <= mem[idx];                    // Ready when stall drops.
        end
        if (sel_i && wait_q) begin
            for (int b = 0; b < BYTES; b++) begin
                if (mask_i[b]) begin
                    mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* verilog/system_timer.sv */
// System timer: free-running count with a writable compare and an interrupt level.
`timescale 1ns/1ns
`include "soc_cfg.svh"

module system_timer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               sel_i,
    input  soc_pkg::bus_addr_t addr_i,
    input  soc_pkg::bus_word_t wdata_i,
    input  soc_pkg::bus_mask_t mask_i,
    output soc_pkg::bus_word_t rdata_o,
    output logic               irq_o
);

    localparam int BYTES = $bits(soc_pkg::bus_mask_t);

    soc_pkg::bus_word_t        count_q;
    soc_pkg::bus_word_t        cmp_q;
    logic                      irq_q;
    logic [`SOC_OFS_BITS-1:0]  ofs;
    logic                      cmp_wr;

    assign ofs    = addr_i[`SOC_OFS_BITS-1:0];
    assign cmp_wr = sel_i && (|mask_i) && (ofs == `SOC_TMR_CMP_OFS);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Counter, compare and interrupt

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            irq_q   <= (cmp_q != '0) && (count_q >= cmp_q);
            if (cmp_wr) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (mask_i[b]) begin
                        cmp_q[8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // Register read back
    always_comb begin
        case (ofs)
            `SOC_TMR_COUNT_OFS: rdata_o = count_q;
            `SOC_TMR_CMP_OFS:   rdata_o = cmp_q;
            default:            rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

endmodule

/* verilog/pwm_regs.sv */
// PWM block: period and duty registers for two channels driven by one shared counter.
`timescale 1ns/1ns
`include "soc_cfg.svh"

module pwm_regs (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               sel_i,
    input  soc_pkg::bus_addr_t addr_i,
    input  soc_pkg::bus_word_t wdata_i,
    input  soc_pkg::bus_mask_t mask_i,
    output soc_pkg::bus_word_t rdata_o,
    output logic               pwm0_o,
    output logic               pwm1_o
);

    localparam int PWM_W = 16;

    logic [PWM_W-1:0]         per0_q, duty0_q, per1_q, duty1_q;
    logic [PWM_W-1:0]         cnt_q;
    logic [PWM_W-1:0]         max_per;
    logic                     pwm0_q, pwm1_q;
    logic [`SOC_OFS_BITS-1:0] ofs;
    logic                     wr;

    assign ofs     = addr_i[`SOC_OFS_BITS-1:0];
    assign wr      = sel_i && (|mask_i);
    assign max_per = (per0_q > per1_q) ? per0_q : per1_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers, shared counter and outputs

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            per0_q  <= '0;
            duty0_q <= '0;
            per1_q  <= '0;
            duty1_q <= '0;
            cnt_q   <= '0;
            pwm0_q  <= 1'b0;
            pwm1_q  <= 1'b0;
        end else begin
            if (wr) begin
                case (ofs)
                    `SOC_PWM_PER0_OFS:  per0_q  <= wdata_i[PWM_W-1:0];
                    `SOC_PWM_DUTY0_OFS: duty0_q <= wdata_i[PWM_W-1:0];
                    `SOC_PWM_PER1_OFS:  per1_q  <= wdata_i[PWM_W-1:0];
                    `SOC_PWM_DUTY1_OFS: duty1_q <= wdata_i[PWM_W-1:0];
                    default: ;
                endcase
            end
            cnt_q  <= (cnt_q + 1'b1 >= max_per) ? '0 : cnt_q + 1'b1;    // Wrap at max period.
            pwm0_q <= (cnt_q < duty0_q) && (cnt_q < per0_q);
            pwm1_q <= (cnt_q < duty1_q) && (cnt_q < per1_q);
        end
    end

    always_comb begin
        case (ofs)
            `SOC_PWM_PER0_OFS:  rdata_o = {16'h0, per0_q};
            `SOC_PWM_DUTY0_OFS: rdata_o = {16'h0, duty0_q};
            `SOC_PWM_PER1_OFS:  rdata_o = {16'h0, per1_q};
            `SOC_PWM_DUTY1_OFS: rdata_o = {16'h0, duty1_q};
            default:            rdata_o = '0;
        endcase
    end

    assign pwm0_o = pwm0_q;
    assign pwm1_o = pwm1_q;

endmodule

/* verilog/read_return_mux.sv */
// Return multiplexer: sends the selected target's read data and stall back to the core.
`timescale 1ns/1ns

module read_return_mux (
    input  soc_pkg::target_e   tgt_i,
    input  soc_pkg::bus_word_t ram_rdata_i,
    input  soc_pkg::bus_word_t tmr_rdata_i,
    input  soc_pkg::bus_word_t pwm_rdata_i,
    input  logic               ram_stall_i,
    output soc_pkg::bus_word_t rdata_o,
    output logic               stall_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data

    always_comb begin
        case (tgt_i)
            soc_pkg::TGT_RAM:   rdata_o = ram_rdata_i;
            soc_pkg::TGT_TIMER: rdata_o = tmr_rdata_i;
            soc_pkg::TGT_PWM:   rdata_o = pwm_rdata_i;
            default:            rdata_o = '0;       // Unmapped reads as zero.
        endcase
    end

    // Only the RAM holds the core.
    assign stall_o = (tgt_i == soc_pkg::TGT_RAM) ? ram_stall_i : 1'b0;

endmodule

/* verilog/data_bus_top.sv */
// Data bus fabric top: decoder, scratch RAM, timer, PWM block and return multiplexer.
`timescale 1ns/1ns

module data_bus_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               bus_sel_i,
    input  soc_pkg::bus_addr_t bus_addr_i,
    input  soc_pkg::bus_word_t bus_wdata_i,
    input  soc_pkg::bus_mask_t bus_mask_i,
    output soc_pkg::bus_word_t bus_rdata_o,
    output logic               bus_stall_o,
    output logic               timer_irq_o,
    output logic               pwm0_o,
    output logic               pwm1_o
);

    logic               ram_sel, tmr_sel, pwm_sel;
    logic               ram_stall;
    soc_pkg::target_e   tgt;
    soc_pkg::bus_word_t ram_rdata, tmr_rdata, pwm_rdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode

    bus_decoder u_dec (
        .bus_sel_i  (bus_sel_i ),
        .bus_addr_i (bus_addr_i),
        .ram_sel_o  (ram_sel   ),
        .tmr_sel_o  (tmr_sel   ),
        .pwm_sel_o  (pwm_sel   ),
        .tgt_o      (tgt       )
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Targets

    scratch_ram u_ram (
        .clk_i   (clk_i      ),
        .rst_n_i (rst_n_i    ),
        .sel_i   (ram_sel    ),
        .addr_i  (bus_addr_i ),
        .wdata_i (bus_wdata_i),
        .mask_i  (bus_mask_i ),
        .rdata_o (ram_rdata  ),
        .stall_o (ram_stall  )
    );

    system_timer u_tmr (
        .clk_i   (clk_i      ),
        .rst_n_i (rst_n_i    ),
        .sel_i   (tmr_sel    ),
        .addr_i  (bus_addr_i ),
        .wdata_i (bus_wdata_i),
        .mask_i  (bus_mask_i ),
        .rdata_o (tmr_rdata  ),
        .irq_o   (timer_irq_o)
    );

    pwm_regs u_pwm (
        .clk_i   (clk_i      ),
        .rst_n_i (rst_n_i    ),
        .sel_i   (pwm_sel    ),
        .addr_i  (bus_addr_i ),
        .wdata_i (bus_wdata_i),
        .mask_i  (bus_mask_i ),
        .rdata_o (pwm_rdata  ),
        .pwm0_o  (pwm0_o     ),
        .pwm1_o  (pwm1_o     )
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result

    read_return_mux u_ret (
        .tgt_i       (tgt        ),
        .ram_rdata_i (ram_rdata  ),
        .tmr_rdata_i (tmr_rdata  ),
        .pwm_rdata_i (pwm_rdata  ),
        .ram_stall_i (ram_stall  ),
        .rdata_o     (bus_rdata_o),
        .stall_o     (bus_stall_o)
    );

endmodule

/* verif/data_bus_assert.sv */
// Handshake checker bound to the data bus top that watches request hold and RAM stall length.
`timescale 1ns/1ns
`include "soc_cfg.svh"

module data_bus_assert (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               sel_i,
    input soc_pkg::bus_addr_t addr_i,
    input logic               stall_i
);

    int unsigned hold_errs   = 0;
    int unsigned len_errs    = 0;
    int unsigned orphan_errs = 0;
    int unsigned fail_cnt;

    assign fail_cnt = hold_errs + len_errs + orphan_errs;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core side must hold the request while stalled.

    addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> sel_i && $stable(addr_i))
        else begin
            hold_errs++;
            $error("Request changed or dropped while the bus was stalled.");
        end

    // A completing RAM access follows exactly one stalled cycle.
    ram_one_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (sel_i && addr_i[`SOC_RAM_SEL_BIT] && !stall_i)
            |-> $past(stall_i) && !$past(stall_i, 2))
        else begin
            len_errs++;
            $error("RAM access did not stall for exactly one cycle.");
        end

    stall_needs_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |-> sel_i)
        else begin
            orphan_errs++;
            $error("Stall raised with no request selected.");
        end

endmodule

bind data_bus_top data_bus_assert u_assert (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .sel_i       (bus_sel_i  ),
    .addr_i      (bus_addr_i ),
    .stall_i     (bus_stall_o)
);

/* verif/tb_clkgen.sv */
// Testbench clock and reset source: 100 ns clock, reset held low for four cycles.
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD = 50;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1;                          // Release just after the fourth edge.
    end

endmodule

/* verif/tb_data_bus.sv */
// Data bus fabric testbench: plays the core with LFSR stimulus against a shadow model.
`timescale 1ns/1ns
`include "soc_cfg.svh"

module tb_data_bus;

    localparam int                 ACCESS_TIMEOUT = 8;
    localparam soc_pkg::bus_addr_t RAM_BASE       = 32'h4000_0000;
    localparam soc_pkg::bus_addr_t TMR_BASE       = 32'h1000_0000;
    localparam soc_pkg::bus_addr_t PWM_BASE       = 32'h2000_0000;

    logic               clk, rst_n;
    logic               bus_sel, bus_stall, timer_irq, pwm0, pwm1;
    soc_pkg::bus_addr_t bus_addr;
    soc_pkg::bus_word_t bus_wdata, bus_rdata;
    soc_pkg::bus_mask_t bus_mask;

    soc_pkg::bus_word_t ram_model [`SOC_RAM_WORDS];
    soc_pkg::bus_word_t cmp_model = '0;
    logic [15:0]        pwm_model [4] = '{default: '0};
    soc_pkg::bus_word_t exp_q [$];
    bit                 chk_q [$];
    soc_pkg::bus_word_t exp_word;
    bit                 exp_chk;
    logic [31:0]        lfsr = 32'ha32b_c51e;
    int                 checks = 0;
    int                 errors = 0;
    int                 base_checks, base_errors;

    tb_clkgen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    data_bus_top u_dut (
        .clk_i       (clk      ),
        .rst_n_i     (rst_n    ),
        .bus_sel_i   (bus_sel  ),
        .bus_addr_i  (bus_addr ),
        .bus_wdata_i (bus_wdata),
        .bus_mask_i  (bus_mask ),
        .bus_rdata_o (bus_rdata),
        .bus_stall_o (bus_stall),
        .timer_irq_o (timer_irq),
        .pwm0_o      (pwm0     ),
        .pwm1_o      (pwm1     )
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus source and reference model

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32, 22, 2, 1.
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic soc_pkg::bus_word_t fill_word(input logic [7:0] i);
        return {i ^ 8'hA5, ~i, i, i ^ 8'h3C};              // Every index bit shows.
    endfunction

    function automatic soc_pkg::bus_word_t merge_bytes(input soc_pkg::bus_word_t old_w,
                                                       input soc_pkg::bus_word_t new_w,
                                                       input soc_pkg::bus_mask_t mask);
        soc_pkg::bus_word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                r[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic void shadow_write(input soc_pkg::bus_addr_t addr,
                                         input soc_pkg::bus_word_t wdata,
                                         input soc_pkg::bus_mask_t mask);
        if (addr[`SOC_RAM_SEL_BIT]) begin
            ram_model[addr[9:2]] = merge_bytes(ram_model[addr[9:2]], wdata, mask);
        end else if (addr[`SOC_TMR_SEL_BIT]) begin
            if (addr[3:0] == `SOC_TMR_CMP_OFS) begin
                cmp_model = merge_bytes(cmp_model, wdata, mask);
            end
        end else if (addr[`SOC_PWM_SEL_BIT]) begin
            if (addr[1:0] == 2'b00 && mask != '0) begin
                pwm_model[addr[3:2]] = wdata[15:0];        // Upper half is dropped.
            end
        end
    endfunction

    function automatic soc_pkg::bus_word_t ref_read(input soc_pkg::bus_addr_t addr);
        if (addr[`SOC_RAM_SEL_BIT]) begin
            return ram_model[addr[9:2]];
        end else if (addr[`SOC_TMR_SEL_BIT]) begin
            return (addr[3:0] == `SOC_TMR_CMP_OFS) ? cmp_model : '0;
        end else if (addr[`SOC_PWM_SEL_BIT]) begin
            return (addr[1:0] == 2'b00) ? {16'h0, pwm_model[addr[3:2]]} : '0;
        end
        return '0;                                         // Unmapped.
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and bus driver

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error @ %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic bus_access(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_word_t wdata,
                              input soc_pkg::bus_mask_t mask,
                              output soc_pkg::bus_word_t rdata, output int stalls);
        int cycles;
        bit done;
        cycles    = 0;
        done      = 1'b0;
        stalls    = 0;
        rdata     = '0;
        bus_sel   = 1'b1;
        bus_addr  = addr;
        bus_wdata = wdata;
        bus_mask  = mask;
        while (!done && cycles < ACCESS_TIMEOUT) begin
            @(negedge clk);
            if (!bus_stall) begin
                rdata = bus_rdata;
                done  = 1'b1;
            end else begin
                stalls++;
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        bus_sel = 1'b0;
        assert (done) else begin
            $display("Timeout: access to %h still stalled after %0d cycles", addr, cycles);
            errors++;
        end
    endtask

    task automatic write_word(input soc_pkg::bus_addr_t addr, input soc_pkg::bus_word_t wdata,
                              input soc_pkg::bus_mask_t mask);
        soc_pkg::bus_word_t unused;
        int                 stalls;
        bus_access(addr, wdata, mask, unused, stalls);
        shadow_write(addr, wdata, mask);
        check_value("bus_stall_o cycles", stalls, addr[`SOC_RAM_SEL_BIT] ? 1 : 0);
    endtask

    task automatic read_word(input soc_pkg::bus_addr_t addr, input bit chk,
                             output soc_pkg::bus_word_t rdata);
        int stalls;
        exp_q.push_back(ref_read(addr));
        chk_q.push_back(chk);
        bus_access(addr, '0, '0, rdata, stalls);
        check_value("bus_stall_o cycles", stalls, addr[`SOC_RAM_SEL_BIT] ? 1 : 0);
    endtask

    // Completed reads are compared against the queued reference values.
    always @(negedge clk) begin
        if (rst_n && bus_sel && !bus_stall && bus_mask == '0) begin
            assert (exp_q.size() != 0) else begin
                $display("Read completed at %0t ns with no expected value queued", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_word = exp_q.pop_front();
                exp_chk  = chk_q.pop_front();
                if (exp_chk) begin
                    check_value("bus_rdata_o", bus_rdata, exp_word);
                end
            end
        end
    end

    task automatic begin_test();
        base_checks = checks;
        base_errors = errors;
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %0d checks, %0d errors", num, name,
                 checks - base_checks, errors - base_errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence

    initial begin
        soc_pkg::bus_addr_t ram_addrs [64];
        soc_pkg::bus_addr_t addr;
        soc_pkg::bus_word_t wdata, rdata, count0, count1;
        soc_pkg::bus_mask_t mask;
        logic [31:0]        hi, idx;
        int                 cycles;
        bit                 seen_hi, seen_lo;

        bus_sel   = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_mask  = '0;
        cycles    = 0;
        while (!rst_n && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        assert (rst_n) else begin
            $display("Timeout: reset was never released");
            errors++;
        end
        #1;

        begin_test();
        @(negedge clk);
        check_value("bus_stall_o", bus_stall, 1'b0);
        check_value("timer_irq_o", timer_irq, 1'b0);
        check_value("pwm0_o", pwm0, 1'b0);
        check_value("pwm1_o", pwm1, 1'b0);
        @(posedge clk);
        #1;
        read_word(TMR_BASE | `SOC_TMR_CMP_OFS, 1'b1, rdata);
        for (int o = 0; o < 16; o += 4) begin
            read_word(PWM_BASE | o, 1'b1, rdata);
        end
        end_test(1, "reset state");

        begin_test();
        for (int i = 0; i < `SOC_RAM_WORDS; i++) begin
            write_word(RAM_BASE | (i << 2), fill_word(i), 4'hF);
        end
        for (int n = 0; n < 64; n++) begin
            hi    = take_bits(2);                          // Bits 29:28 lose to bit 30.
            idx   = take_bits(8);
            wdata = take_bits(32);
            mask  = take_bits(4);
            if (mask == '0) begin
                mask = 4'h1;
            end
            addr         = RAM_BASE | (hi << 28) | (idx << 2);
            ram_addrs[n] = addr;
            write_word(addr, wdata, mask);
        end
        for (int n = 0; n < 64; n++) begin
            read_word(ram_addrs[n], 1'b1, rdata);
        end
        end_test(2, "RAM random access");

        begin_test();
        for (int n = 0; n < 8; n++) begin
            hi    = take_bits(1);
            idx   = take_bits(8);
            wdata = take_bits(32);
            addr  = (hi << 31) | (idx << 2);               // Decode bits clear.
            write_word(addr, wdata, 4'hF);
            read_word(addr, 1'b1, rdata);
            read_word(RAM_BASE | (idx << 2), 1'b1, rdata);
        end
        read_word(TMR_BASE | `SOC_TMR_CMP_OFS, 1'b1, rdata);
        read_word(PWM_BASE | `SOC_PWM_PER1_OFS, 1'b1, rdata);
        end_test(3, "zero-wait and unmapped");

        begin_test();
        read_word(TMR_BASE | `SOC_TMR_COUNT_OFS, 1'b0, count0);
        repeat (10) @(posedge clk);
        #1;
        read_word(TMR_BASE | `SOC_TMR_COUNT_OFS, 1'b0, count1);
        checks++;
        assert (count1 - count0 >= 32'd10) else begin
            $display("** Error @ %0t ns: timer count delta = %0d, expected at least 10",
                     $time, count1 - count0);
            errors++;
        end
        wdata = take_bits(32);
        write_word(TMR_BASE | `SOC_TMR_CMP_OFS, wdata, 4'b0101);
        read_word(TMR_BASE | `SOC_TMR_CMP_OFS, 1'b1, rdata);
        read_word(TMR_BASE | `SOC_TMR_COUNT_OFS, 1'b0, count0);
        write_word(TMR_BASE | `SOC_TMR_CMP_OFS, count0 + 32'd30, 4'hF);
        @(posedge clk);
        @(negedge clk);
        check_value("timer_irq_o", timer_irq, 1'b0);       // Compare still ahead.
        cycles = 0;
        while (timer_irq !== 1'b1 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        assert (timer_irq === 1'b1) else begin
            $display("Timeout: timer_irq_o did not rise within 100 cycles");
            errors++;
        end
        repeat (16) begin
            @(negedge clk);
            check_value("timer_irq_o", timer_irq, 1'b1);
        end
        @(posedge clk);
        #1;
        end_test(4, "system timer");

        begin_test();
        for (int r = 0; r < 2; r++) begin
            for (int o = 0; o < 16; o += 4) begin
                wdata = take_bits(32);
                write_word(PWM_BASE | o, wdata, 4'hF);
                read_word(PWM_BASE | o, 1'b1, rdata);
            end
        end
        end_test(5, "PWM registers");

        begin_test();
        write_word(PWM_BASE | `SOC_PWM_PER0_OFS, 32'd8, 4'hF);
        write_word(PWM_BASE | `SOC_PWM_DUTY0_OFS, 32'd0, 4'hF);
        write_word(PWM_BASE | `SOC_PWM_PER1_OFS, 32'd8, 4'hF);
        write_word(PWM_BASE | `SOC_PWM_DUTY1_OFS, 32'd8, 4'hF);
        repeat (2) @(posedge clk);
        for (int s = 0; s < 16; s++) begin
            @(negedge clk);
            check_value("pwm0_o", pwm0, 1'b0);
            check_value("pwm1_o", pwm1, 1'b1);
        end
        @(posedge clk);
        #1;
        write_word(PWM_BASE | `SOC_PWM_DUTY0_OFS, 32'd3, 4'hF);
        seen_hi = 1'b0;
        seen_lo = 1'b0;
        cycles  = 0;
        while (!(seen_hi && seen_lo) && cycles < 40) begin
            @(negedge clk);
            if (pwm0) begin
                seen_hi = 1'b1;
            end else begin
                seen_lo = 1'b1;
            end
            cycles++;
        end
        assert (seen_hi && seen_lo) else begin
            $display("Timeout: pwm0_o did not toggle with duty 3 of period 8");
            errors++;
        end
        @(posedge clk);
        #1;
        end_test(6, "PWM outputs");

        assert (exp_q.size() == 0) else begin
            $display("%0d reads were queued but never completed", exp_q.size());
            errors++;
        end
        $display("Totals: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, u_dut.u_assert.fail_cnt);
        if (errors == 0 && u_dut.u_assert.fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/system_timer.sv
verilog/pwm_regs.sv
verilog/read_return_mux.sv
verilog/data_bus_top.sv
verif/data_bus_assert.sv
verif/tb_clkgen.sv
verif/tb_data_bus.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_data_bus
FLIST      := flist.f
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
